/* design/isa_pkg.sv */
// Instruction set package: data widths, opcodes, instruction layout and memory size
package isa_pkg;

  // Register file depth and data memory depth in words
  localparam int num_regs  = 32;
  localparam int mem_words = 64;

  // Architectural data word
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

  // Raw immediate as it sits in the instruction, two's complement
  typedef logic signed [12:0] imm_t;

  // Data memory word address, low six bits of the effective address
  typedef logic [5:0] mem_addr_t;

  // Operation codes, 4-bit field at the top of the instruction
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_addi = 4'd6,
    op_lw   = 4'd7,
    op_sw   = 4'd8
  } opcode_t;

  // Instruction word, most significant field first
  // Register ops use rd, rs1, rs2
  // addi and lw use rd, rs1, imm
  // sw stores rs2 at rs1 + imm
  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    imm_t     imm;
  } instr_t;

endpackage

/* design/pipe_pkg.sv */
// Pipeline package: stage records between decode, execute and result, and the retire record
package pipe_pkg;

  // Decode register contents
  typedef struct packed {
    isa_pkg::opcode_t  opcode;
    isa_pkg::reg_idx_t rd;
    // Source values read from the register file
    isa_pkg::word_t    op_a;
    isa_pkg::word_t    op_b;
    // Immediate, already sign extended to a full word
    isa_pkg::word_t    imm_ext;
    // Controls derived from the opcode
    logic              reg_write;
    logic              mem_to_reg;
    logic              mem_write;
  } dec_rec_t;

  // Execution register contents, between the ALU and the memory side
  typedef struct packed {
    isa_pkg::opcode_t  opcode;
    isa_pkg::word_t    imm_ext;
    logic              mem_to_reg;
    logic              reg_write;
    logic              mem_write;
    // Destination register index
    isa_pkg::reg_idx_t dest;
    isa_pkg::word_t    alu_result;
    // Set when alu_result is all zero
    logic              zero;
    // Operand b, written to memory by sw
    isa_pkg::word_t    store_data;
  } exe_rec_t;

  // One record per retired instruction on the output stream
  typedef struct packed {
    isa_pkg::opcode_t  opcode;
    isa_pkg::reg_idx_t rd;
    logic              reg_write;
    // Writeback value, or the stored word for sw
    isa_pkg::word_t    value;
    logic              zero;
  } retire_t;

endpackage

/* design/reg_file.sv */
// Register file: 32 words, two asynchronous read ports, one clocked write port
module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  isa_pkg::reg_idx_t rs1,
  input  isa_pkg::reg_idx_t rs2,
  output isa_pkg::word_t    rd_a,
  output isa_pkg::word_t    rd_b,
  input  logic              wr_en,
  input  isa_pkg::reg_idx_t wr_idx,
  input  isa_pkg::word_t    wr_data
);

  // Register storage
  isa_pkg::word_t regs [isa_pkg::num_regs];

  // Clear on reset, then one write per edge
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < isa_pkg::num_regs; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en && (wr_idx != '0))
    begin
      // Index zero never takes a write
      regs[wr_idx] <= wr_data;
    end
  end

  // Reads are combinational
  // A write lands at the edge, so a reader sees it the cycle after
  // Register zero stays zero since it is cleared and never written
  assign rd_a = regs[rs1];
  assign rd_b = regs[rs2];

endmodule

/* design/decode_stage.sv */
// Decode stage: instruction intake, field split, operand read, hazard interlock, decode register
module decode_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  isa_pkg::instr_t    in_instr,
  output logic               in_ready,
  input  logic               advance,
  output isa_pkg::reg_idx_t  rs1,
  output isa_pkg::reg_idx_t  rs2,
  input  isa_pkg::word_t     rd_a,
  input  isa_pkg::word_t     rd_b,
  input  logic               exe_valid,
  input  pipe_pkg::exe_rec_t exe_rec,
  output logic               dec_valid,
  output pipe_pkg::dec_rec_t dec_rec
);

  // Opcode derived controls
  logic           use_rs1;
  logic           use_rs2;
  logic           reg_write;
  logic           mem_to_reg;
  logic           mem_write;
  // Interlock terms
  logic           dec_pending;
  logic           exe_pending;
  logic           rs1_busy;
  logic           rs2_busy;
  logic           hazard;
  // Intake enable, set one cycle after reset
  logic           started;
  logic           take;
  isa_pkg::word_t imm_ext;

  // Source indices go straight to the register file
  assign rs1 = in_instr.rs1;
  assign rs2 = in_instr.rs2;

  // Sign extend 13 bits to a word
  assign imm_ext = {{19{in_instr.imm[12]}}, in_instr.imm};

  // Control decode, unknown opcodes behave as nop
  always_comb
  begin
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    reg_write  = 1'b0;
    mem_to_reg = 1'b0;
    mem_write  = 1'b0;
    case (in_instr.opcode)
      isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
      isa_pkg::op_or, isa_pkg::op_xor:
      begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        reg_write = 1'b1;
      end
      isa_pkg::op_addi:
      begin
        use_rs1   = 1'b1;
        reg_write = 1'b1;
      end
      isa_pkg::op_lw:
      begin
        use_rs1    = 1'b1;
        reg_write  = 1'b1;
        mem_to_reg = 1'b1;
      end
      // Base in rs1, data in rs2
      isa_pkg::op_sw:
      begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        mem_write = 1'b1;
      end
      default:
      begin
        use_rs1 = 1'b0;
      end
    endcase
  end

  // Writes still in flight, register zero never counts
  assign dec_pending = dec_valid && dec_rec.reg_write && (dec_rec.rd != '0);
  assign exe_pending = exe_valid && exe_rec.reg_write && (exe_rec.dest != '0);

  assign rs1_busy = (dec_pending && (dec_rec.rd == rs1)) || (exe_pending && (exe_rec.dest == rs1));
  assign rs2_busy = (dec_pending && (dec_rec.rd == rs2)) || (exe_pending && (exe_rec.dest == rs2));

  // Only sources the opcode reads can stall it
  assign hazard = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);

  assign in_ready = started && advance && !hazard;
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      started <= 1'b0;
    end
    else
    begin
      started <= 1'b1;
    end
  end

  // Decode register, holds while the pipeline is stalled
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dec_valid <= 1'b0;
      dec_rec   <= '0;
    end
    else if (advance)
    begin
      // Bubble when nothing transfers
      dec_valid <= take;
      if (take)
      begin
        dec_rec.opcode     <= in_instr.opcode;
        dec_rec.rd         <= in_instr.rd;
        dec_rec.op_a       <= rd_a;
        dec_rec.op_b       <= rd_b;
        dec_rec.imm_ext    <= imm_ext;
        dec_rec.reg_write  <= reg_write;
        dec_rec.mem_to_reg <= mem_to_reg;
        dec_rec.mem_write  <= mem_write;
      end
    end
  end

endmodule

/* design/execute_stage.sv */
// Execute stage: ALU and the execution register feeding the memory and writeback side
module execute_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               advance,
  input  logic               dec_valid,
  input  pipe_pkg::dec_rec_t dec_rec,
  output logic               exe_valid,
  output pipe_pkg::exe_rec_t exe_rec
);

  // ALU output and its zero flag
  isa_pkg::word_t alu_result;
  logic           alu_zero;

  // ALU
  always_comb
  begin
    case (dec_rec.opcode)
      isa_pkg::op_add:
      begin
        alu_result = dec_rec.op_a + dec_rec.op_b;
      end
      isa_pkg::op_sub:
      begin
        alu_result = dec_rec.op_a - dec_rec.op_b;
      end
      isa_pkg::op_and:
      begin
        alu_result = dec_rec.op_a & dec_rec.op_b;
      end
      isa_pkg::op_or:
      begin
        alu_result = dec_rec.op_a | dec_rec.op_b;
      end
      isa_pkg::op_xor:
      begin
        alu_result = dec_rec.op_a ^ dec_rec.op_b;
      end
      // Immediate add, also the effective address of lw and sw
      isa_pkg::op_addi, isa_pkg::op_lw, isa_pkg::op_sw:
      begin
        alu_result = dec_rec.op_a + dec_rec.imm_ext;
      end
      // nop and unknown opcodes
      default:
      begin
        alu_result = '0;
      end
    endcase
  end

  assign alu_zero = (alu_result == '0);

  // Execution register, every field moves together on advance
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      exe_valid <= 1'b0;
      exe_rec   <= '0;
    end
    else if (advance)
    begin
      exe_valid             <= dec_valid;
      exe_rec.opcode        <= dec_rec.opcode;
      exe_rec.imm_ext       <= dec_rec.imm_ext;
      exe_rec.mem_to_reg    <= dec_rec.mem_to_reg;
      exe_rec.reg_write     <= dec_rec.reg_write;
      exe_rec.mem_write     <= dec_rec.mem_write;
      exe_rec.dest          <= dec_rec.rd;
      exe_rec.alu_result    <= alu_result;
      exe_rec.zero          <= alu_zero;
      // Operand b rides along as sw data
      exe_rec.store_data    <= dec_rec.op_b;
    end
  end

endmodule

/* design/result_stage.sv */
// Result stage: data memory access, register writeback and the retire output register
module result_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               advance,
  input  logic               exe_valid,
  input  pipe_pkg::exe_rec_t exe_rec,
  output logic               wr_en,
  output isa_pkg::reg_idx_t  wr_idx,
  output isa_pkg::word_t     wr_data,
  output logic               out_valid,
  output pipe_pkg::retire_t  out_rec
);

  // Data memory
  isa_pkg::word_t    mem [isa_pkg::mem_words];
  isa_pkg::mem_addr_t mem_addr;
  isa_pkg::word_t    load_data;
  logic              store_en;
  // Value written back, and the value reported on retire
  isa_pkg::word_t    wb_data;
  isa_pkg::word_t    retire_value;

  // Word address wraps on the low six bits
  assign mem_addr  = exe_rec.alu_result[5:0];
  assign load_data = mem[mem_addr];

  // Store and writeback only fire when the record actually leaves
  assign store_en = advance && exe_valid && exe_rec.mem_write;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < isa_pkg::mem_words; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (store_en)
    begin
      mem[mem_addr] <= exe_rec.store_data;
    end
  end

  // lw takes the memory word, everything else the ALU result
  assign wb_data = exe_rec.mem_to_reg ? load_data : exe_rec.alu_result;

  // Register file write port
  assign wr_en   = advance && exe_valid && exe_rec.reg_write;
  assign wr_idx  = exe_rec.dest;
  assign wr_data = wb_data;

  // sw reports the word it stored
  assign retire_value = exe_rec.mem_write ? exe_rec.store_data : wb_data;

  // Retire register, held while out_ready is low
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      out_rec   <= '0;
    end
    else if (advance)
    begin
      out_valid         <= exe_valid;
      out_rec.opcode    <= exe_rec.opcode;
      out_rec.rd        <= exe_rec.dest;
      out_rec.reg_write <= exe_rec.reg_write;
      out_rec.value     <= retire_value;
      // Flag from the ALU, not recomputed from value
      out_rec.zero      <= exe_rec.zero;
    end
  end

endmodule

/* design/core_top.sv */
// Core top: three-stage pipeline slice with register file and global advance
module core_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  isa_pkg::instr_t   in_instr,
  output logic              in_ready,
  output logic              out_valid,
  output pipe_pkg::retire_t out_rec,
  input  logic              out_ready
);

  // Whole pipeline moves when the retire slot is free or draining
  logic               advance;
  // Register file ports
  isa_pkg::reg_idx_t  rs1;
  isa_pkg::reg_idx_t  rs2;
  isa_pkg::word_t     rd_a;
  isa_pkg::word_t     rd_b;
  logic               wr_en;
  isa_pkg::reg_idx_t  wr_idx;
  isa_pkg::word_t     wr_data;
  // Stage records
  logic               dec_valid;
  pipe_pkg::dec_rec_t dec_rec;
  logic               exe_valid;
  pipe_pkg::exe_rec_t exe_rec;

  assign advance = !out_valid || out_ready;

  decode_stage u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_ready  (in_ready),
    .advance   (advance),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .exe_valid (exe_valid),
    .exe_rec   (exe_rec),
    .dec_valid (dec_valid),
    .dec_rec   (dec_rec)
  );

  execute_stage u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance   (advance),
    .dec_valid (dec_valid),
    .dec_rec   (dec_rec),
    .exe_valid (exe_valid),
    .exe_rec   (exe_rec)
  );

  result_stage u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance   (advance),
    .exe_valid (exe_valid),
    .exe_rec   (exe_rec),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .out_valid (out_valid),
    .out_rec   (out_rec)
  );

  reg_file u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd_a    (rd_a),
    .rd_b    (rd_b),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data)
  );

endmodule

/* bench/core_checker.sv */
// Retire checker: reference model of the instruction set, expected retire queue and comparison
module core_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  isa_pkg::instr_t   in_instr,
  input  logic              in_ready,
  input  logic              out_valid,
  input  pipe_pkg::retire_t out_rec,
  input  logic              out_ready,
  input  logic              latency_check,
  output int                outstanding
);
  timeunit 1ns;
  timeprecision 1ps;

  // Edges from acceptance to the retire transfer with out_ready held high
  localparam int pipe_latency = 3;

  // Architectural state as the instruction set defines it
  isa_pkg::word_t    model_regs [isa_pkg::num_regs];
  isa_pkg::word_t    model_mem [isa_pkg::mem_words];
  // Expected records and the cycle each instruction was accepted
  pipe_pkg::retire_t exp_q [$];
  int                accept_q [$];
  pipe_pkg::retire_t head_rec;
  int                head_cycle;
  pipe_pkg::retire_t new_rec;
  // Last record seen while the output was stalled
  logic              held_valid;
  pipe_pkg::retire_t held_rec;
  // Pending writes in the decode and execution slots, rd zero excluded
  logic              slot_dec_wr;
  isa_pkg::reg_idx_t slot_dec_rd;
  logic              slot_exe_wr;
  isa_pkg::reg_idx_t slot_exe_rd;
  // Intake stays closed in the first cycle after reset
  logic              ready_armed;
  logic              advance_seen;
  logic              exp_ready;
  int                cycle = 0;
  int                mismatch_errors = 0;
  int                protocol_errors = 0;
  string             test_name = "reset";

  task start_test(input string name);
    test_name = name;
    $display("Running test %s", name);
  endtask

  function automatic string rec_text(input pipe_pkg::retire_t r);
    return $sformatf("{op=%0d rd=%0d wr=%0b value=%08h zero=%0b}",
                     r.opcode, r.rd, r.reg_write, r.value, r.zero);
  endfunction

  // True when a source the instruction reads is still to be written by an older one
  function automatic logic reads_pending(input isa_pkg::instr_t instr);
    logic use_a;
    logic use_b;
    logic hit_a;
    logic hit_b;
    use_a = instr.opcode inside {isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
                                 isa_pkg::op_or, isa_pkg::op_xor, isa_pkg::op_addi,
                                 isa_pkg::op_lw, isa_pkg::op_sw};
    use_b = instr.opcode inside {isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
                                 isa_pkg::op_or, isa_pkg::op_xor, isa_pkg::op_sw};
    hit_a = (slot_dec_wr && (slot_dec_rd == instr.rs1)) ||
            (slot_exe_wr && (slot_exe_rd == instr.rs1));
    hit_b = (slot_dec_wr && (slot_dec_rd == instr.rs2)) ||
            (slot_exe_wr && (slot_exe_rd == instr.rs2));
    return (use_a && hit_a) || (use_b && hit_b);
  endfunction

  // Applies one instruction to the model and returns its retire record
  function automatic pipe_pkg::retire_t predict_retire(input isa_pkg::instr_t instr);
    isa_pkg::word_t    a;
    isa_pkg::word_t    b;
    isa_pkg::word_t    imm;
    isa_pkg::word_t    addr_sum;
    isa_pkg::word_t    alu;
    pipe_pkg::retire_t r;
    a           = model_regs[instr.rs1];
    b           = model_regs[instr.rs2];
    imm         = 32'($signed(instr.imm));
    addr_sum    = a + imm;
    r           = '0;
    r.opcode    = instr.opcode;
    r.rd        = instr.rd;
    r.reg_write = 1'b1;
    case (instr.opcode)
      isa_pkg::op_add:  alu = a + b;
      isa_pkg::op_sub:  alu = a - b;
      isa_pkg::op_and:  alu = a & b;
      isa_pkg::op_or:   alu = a | b;
      isa_pkg::op_xor:  alu = a ^ b;
      isa_pkg::op_addi: alu = addr_sum;
      isa_pkg::op_lw:   alu = addr_sum;
      isa_pkg::op_sw:   alu = addr_sum;
      default:          alu = '0;
    endcase
    r.value = alu;
    r.zero  = (alu == '0);
    if (instr.opcode == isa_pkg::op_lw)
    begin
      // Word address is the low six bits, so it wraps
      r.value = model_mem[addr_sum[5:0]];
    end
    else if (instr.opcode == isa_pkg::op_sw)
    begin
      r.reg_write                = 1'b0;
      r.value                    = b;
      model_mem[addr_sum[5:0]]   = b;
    end
    else if (instr.opcode == isa_pkg::op_nop)
    begin
      r.reg_write = 1'b0;
    end
    // Register zero reports the write but keeps zero
    if (r.reg_write && (instr.rd != '0))
    begin
      model_regs[instr.rd] = r.value;
    end
    return r;
  endfunction

  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (!rst_n)
    begin
      for (int i = 0; i < isa_pkg::num_regs; i++)
      begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < isa_pkg::mem_words; i++)
      begin
        model_mem[i] = '0;
      end
      exp_q.delete();
      accept_q.delete();
      held_valid  = 1'b0;
      new_rec     = '0;
      slot_dec_wr = 1'b0;
      slot_dec_rd = '0;
      slot_exe_wr = 1'b0;
      slot_exe_rd = '0;
      ready_armed = 1'b0;
      outstanding <= 0;
    end
    else
    begin
      // Intake stalls only for a held retire slot or a read of a pending write
      advance_seen = !out_valid || out_ready;
      exp_ready    = ready_armed && advance_seen && !reads_pending(in_instr);
      if (in_ready !== exp_ready)
      begin
        mismatch_errors++;
        $display("CHECK FAILED test=%s in_ready expected=%0b actual=%0b",
                 test_name, exp_ready, in_ready);
      end
      ready_armed = 1'b1;
      // A stalled record must stay put until it is taken
      if (held_valid && (!out_valid || (out_rec !== held_rec)))
      begin
        protocol_errors++;
        $display("ERROR: test %s: retire record changed while out_ready was low", test_name);
      end
      held_valid = out_valid && !out_ready;
      held_rec   = out_rec;
      if (out_valid && out_ready)
      begin
        if (exp_q.size() == 0)
        begin
          protocol_errors++;
          $display("ERROR: test %s: retire record came out with no instruction in flight",
                   test_name);
        end
        else
        begin
          head_rec   = exp_q.pop_front();
          head_cycle = accept_q.pop_front();
          if (out_rec !== head_rec)
          begin
            mismatch_errors++;
            $display("CHECK FAILED test=%s expected=%s actual=%s",
                     test_name, rec_text(head_rec), rec_text(out_rec));
          end
          if (latency_check && ((cycle - head_cycle) != pipe_latency))
          begin
            mismatch_errors++;
            $display("CHECK FAILED test=%s latency expected=%0d actual=%0d",
                     test_name, pipe_latency, cycle - head_cycle);
          end
        end
      end
      // Model runs in program order at acceptance
      if (in_valid && in_ready)
      begin
        new_rec = predict_retire(in_instr);
        exp_q.push_back(new_rec);
        accept_q.push_back(cycle);
      end
      // Slots shift with the pipeline and take a bubble when nothing transfers
      if (advance_seen)
      begin
        slot_exe_wr = slot_dec_wr;
        slot_exe_rd = slot_dec_rd;
        slot_dec_wr = in_valid && in_ready && new_rec.reg_write && (new_rec.rd != '0);
        slot_dec_rd = in_instr.rd;
      end
      outstanding <= exp_q.size();
    end
  end

  // Closing line with all counts where leftover records count as errors
  task final_report(output int total);
    int leftover;
    leftover = exp_q.size();
    if (leftover != 0)
    begin
      $display("ERROR: %0d expected retire records never came out", leftover);
    end
    total = mismatch_errors + protocol_errors + leftover;
    $display("Summary: %0d mismatches, %0d protocol errors, %0d missing, %0d errors in total",
             mismatch_errors, protocol_errors, leftover, total);
  endtask

endmodule

/* bench/core_tb.sv */
// Pipeline testbench: clock, reset, directed and random programs, back-pressure and watchdog
module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 20;
  localparam int n_random   = 200;
  // Upper bound on the directed instructions plus two random runs
  localparam int total_instr     = 60 + 2 * n_random;
  localparam int watchdog_cycles = total_instr * 20 + 500;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  isa_pkg::instr_t   in_instr;
  logic              in_ready;
  logic              out_valid;
  pipe_pkg::retire_t out_rec;
  logic              out_ready;
  // Test controls
  logic              bp_on;
  logic              latency_check;
  int                outstanding;
  int                errors;

  core_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_rec   (out_rec),
    .out_ready (out_ready)
  );

  core_checker u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_rec       (out_rec),
    .out_ready     (out_ready),
    .latency_check (latency_check),
    .outstanding   (outstanding)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Output back-pressure with roughly 40 percent stall cycles when enabled
  initial
  begin
    out_ready = 1'b0;
    forever
    begin
      @(posedge clk);
      if (bp_on)
      begin
        out_ready <= (($urandom % 100) >= 40);
      end
      else
      begin
        out_ready <= 1'b1;
      end
    end
  end

  function automatic isa_pkg::instr_t make_instr(input isa_pkg::opcode_t op, input int rd,
                                                  input int rs1, input int rs2, input int imm);
    isa_pkg::instr_t i;
    i.opcode = op;
    i.rd     = isa_pkg::reg_idx_t'(rd);
    i.rs1    = isa_pkg::reg_idx_t'(rs1);
    i.rs2    = isa_pkg::reg_idx_t'(rs2);
    i.imm    = isa_pkg::imm_t'(imm);
    return i;
  endfunction

  // Independent programs write r16..r31 and read r1..r15 only
  function automatic isa_pkg::instr_t random_instr(input bit independent);
    isa_pkg::opcode_t op;
    int               rd;
    int               rs1;
    int               rs2;
    op = isa_pkg::opcode_t'(4'($urandom % 9));
    if (independent)
    begin
      rd  = 16 + int'($urandom % 16);
      rs1 = 1 + int'($urandom % 15);
      rs2 = 1 + int'($urandom % 15);
    end
    else
    begin
      rd  = int'($urandom % 8);
      rs1 = int'($urandom % 8);
      rs2 = int'($urandom % 8);
    end
    return make_instr(op, rd, rs1, rs2, int'($urandom % 8192) - 4096);
  endfunction

  // Holds the instruction until it transfers
  task automatic send(input isa_pkg::instr_t instr);
    in_valid <= 1'b1;
    in_instr <= instr;
    do
    begin
      @(posedge clk);
    end
    while (!in_ready);
  endtask

  task automatic drain();
    in_valid <= 1'b0;
    @(posedge clk);
    while (outstanding != 0)
    begin
      @(posedge clk);
    end
  endtask

  task automatic run_alu_ops();
    send(make_instr(isa_pkg::op_addi, 1, 0, 0, 25));
    send(make_instr(isa_pkg::op_addi, 2, 0, 0, -7));
    send(make_instr(isa_pkg::op_addi, 3, 0, 0, 25));
    send(make_instr(isa_pkg::op_add, 4, 1, 2, 0));
    // Equal operands give zero and set the flag
    send(make_instr(isa_pkg::op_sub, 5, 1, 3, 0));
    send(make_instr(isa_pkg::op_and, 6, 1, 2, 0));
    send(make_instr(isa_pkg::op_or, 7, 2, 4, 0));
    send(make_instr(isa_pkg::op_xor, 8, 1, 3, 0));
    send(make_instr(isa_pkg::op_addi, 9, 2, 0, 7));
    send(make_instr(isa_pkg::op_nop, 0, 0, 0, 0));
  endtask

  // Every instruction reads the previous destination
  task automatic run_dep_chain();
    send(make_instr(isa_pkg::op_addi, 10, 0, 0, 3));
    for (int k = 0; k < 8; k++)
    begin
      if (k % 2 == 0)
      begin
        send(make_instr(isa_pkg::op_add, 10, 10, 10, 0));
      end
      else
      begin
        send(make_instr(isa_pkg::op_addi, 10, 10, 0, -1));
      end
    end
    send(make_instr(isa_pkg::op_xor, 11, 10, 10, 0));
    send(make_instr(isa_pkg::op_sub, 12, 10, 11, 0));
  endtask

  task automatic run_reg_zero();
    send(make_instr(isa_pkg::op_addi, 0, 0, 0, 99));
    send(make_instr(isa_pkg::op_add, 11, 0, 0, 0));
    send(make_instr(isa_pkg::op_addi, 0, 1, 0, 5));
    send(make_instr(isa_pkg::op_addi, 12, 0, 0, 7));
    send(make_instr(isa_pkg::op_or, 13, 0, 1, 0));
  endtask

  // Addresses 69 and -1 wrap to 5 and 63
  task automatic run_mem_wrap();
    send(make_instr(isa_pkg::op_addi, 14, 0, 0, 4660));
    send(make_instr(isa_pkg::op_sw, 0, 0, 14, 5));
    send(make_instr(isa_pkg::op_lw, 15, 0, 0, 5));
    send(make_instr(isa_pkg::op_addi, 16, 0, 0, 77));
    send(make_instr(isa_pkg::op_sw, 0, 0, 16, 69));
    send(make_instr(isa_pkg::op_lw, 17, 0, 0, 5));
    send(make_instr(isa_pkg::op_lw, 18, 0, 0, 69));
    send(make_instr(isa_pkg::op_sw, 0, 0, 14, -1));
    send(make_instr(isa_pkg::op_lw, 19, 0, 0, 63));
    send(make_instr(isa_pkg::op_lw, 20, 0, 0, 6));
    send(make_instr(isa_pkg::op_addi, 21, 0, 0, 10));
    send(make_instr(isa_pkg::op_sw, 0, 21, 16, 0));
    send(make_instr(isa_pkg::op_lw, 22, 21, 0, 0));
    send(make_instr(isa_pkg::op_lw, 23, 0, 0, 10));
    // Load result feeding an ALU op
    send(make_instr(isa_pkg::op_add, 24, 15, 17, 0));
  endtask

  task automatic run_random(input bit independent);
    for (int k = 0; k < n_random; k++)
    begin
      send(random_instr(independent));
    end
  endtask

  initial
  begin
    void'($urandom(63));
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_instr      = '0;
    bp_on         = 1'b0;
    latency_check = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    latency_check <= 1'b1;
    u_chk.start_test("alu_ops");
    run_alu_ops();
    drain();
    u_chk.start_test("dep_chain");
    run_dep_chain();
    drain();
    u_chk.start_test("reg_zero");
    run_reg_zero();
    drain();
    u_chk.start_test("mem_wrap");
    run_mem_wrap();
    drain();
    // Stall cycles stretch latency, so only the records are compared
    latency_check <= 1'b0;
    bp_on         <= 1'b1;
    u_chk.start_test("random_backpressure");
    run_random(1'b0);
    drain();
    bp_on         <= 1'b0;
    latency_check <= 1'b1;
    u_chk.start_test("random_latency");
    run_random(1'b1);
    drain();
    repeat (5) @(posedge clk);
    u_chk.final_report(errors);
    if (errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the pipeline stopped making progress",
             watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* sources.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core_top.sv
bench/core_checker.sv
bench/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       := core_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
